/* hdl/wb_pkg.sv */
package wb_pkg;

   ////////////////////////////////////////
   // 16-bit wishbone, single master

   localparam int wb_dw = 16;       // data
   localparam int wb_aw = 11;       // byte address
   localparam int wb_sw = 2;        // byte selects
   localparam int wb_decode_w = 4;  // top address bits that pick the slave

   // master to slave
   typedef struct packed
   {
      logic [wb_aw-1:0] adr;
      logic [wb_dw-1:0] dat;
      logic [wb_sw-1:0] sel;
      logic             we;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   // slave to master
   typedef struct packed
   {
      logic [wb_dw-1:0] dat;
      logic             ack;
   } wb_rsp_t;

endpackage

/* hdl/regmap_pkg.sv */
package regmap_pkg;

   ////////////////////////////////////////
   // slave map, adr[10:7]

   localparam logic [wb_pkg::wb_decode_w-1:0] slv_misc = 4'd0;
   localparam logic [wb_pkg::wb_decode_w-1:0] slv_readback = 4'd7;
   localparam logic [wb_pkg::wb_decode_w-1:0] slv_settings = 4'd8;
   localparam logic [wb_pkg::wb_decode_w-1:0] slv_mask_one = 4'hF;
   localparam logic [wb_pkg::wb_decode_w-1:0] slv_mask_settings = 4'hE; // 8 and 9

   ////////////////////////////////////////
   // slave 0 byte offsets

   localparam logic [6:0] reg_leds = 7'd0;       // out
   localparam logic [6:0] reg_cgen_ctrl = 7'd4;  // out
   localparam logic [6:0] reg_cgen_st = 7'd6;    // in
   localparam logic [6:0] reg_test = 7'd8;       // out
   localparam logic [6:0] reg_compat = 7'd16;    // in

   localparam logic [7:0] compat_num = 8'd3;
   localparam logic [1:0] cgen_ctrl_reset = 2'b11;  // sync_b and ref_sel high
   localparam logic [15:0] unmapped_read = 16'hBEEF;

   ////////////////////////////////////////
   // settings bus

   localparam int set_rw = 6;  // 64 settings of 32 bits

   localparam logic [set_rw-1:0] sr_time64 = 6'd40;      // hi word, lo word at +1
   localparam logic [set_rw-1:0] sr_reg_test32 = 6'd52;

   typedef struct packed
   {
      logic              stb;   // one cycle per setting write
      logic [set_rw-1:0] addr;
      logic [31:0]       data;
   } set_bus_t;

endpackage

/* hdl/wb_slave_decode.sv */
`timescale 1ns/10ps

module wb_slave_decode
  (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  wb_pkg::wb_req_t  m_req_i,
   output wb_pkg::wb_rsp_t  m_rsp_o,
   output wb_pkg::wb_req_t  misc_req_o,
   output wb_pkg::wb_req_t  rb_req_o,
   output wb_pkg::wb_req_t  set_req_o,
   input  wb_pkg::wb_rsp_t  misc_rsp_i,
   input  wb_pkg::wb_rsp_t  rb_rsp_i,
   input  wb_pkg::wb_rsp_t  set_rsp_i
  );
   import wb_pkg::*;
   import regmap_pkg::*;

   typedef struct packed
   {
      logic misc;
      logic rb;
      logic set;
   } slv_sel_t;

   logic [wb_decode_w-1:0] dec;
   slv_sel_t sel_now;   // from the current address
   slv_sel_t sel_q;     // held for the rest of the access
   slv_sel_t sel;
   logic     lock_q;

   function automatic logic slave_hit(input logic [wb_decode_w-1:0] a,
                                      input logic [wb_decode_w-1:0] base,
                                      input logic [wb_decode_w-1:0] mask);
      slave_hit = ((a ^ base) & mask) == '0;
   endfunction

   function automatic wb_req_t gate_req(input wb_req_t r, input logic en);
      wb_req_t g;
      g = r;
      g.cyc = r.cyc & en;
      g.stb = r.stb & en;
      return g;
   endfunction

   ////////////////////////////////////////
   // decode

   assign dec = m_req_i.adr[wb_aw-1 -: wb_decode_w];

   always_comb
   begin
      sel_now.misc = slave_hit(dec, slv_misc, slv_mask_one);
      sel_now.rb = slave_hit(dec, slv_readback, slv_mask_one);
      sel_now.set = slave_hit(dec, slv_settings, slv_mask_settings);
   end

   // route is frozen once an access has started and not yet acked
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         lock_q <= 1'b0;
         sel_q <= '0;
      end
      else
      begin
         lock_q <= m_req_i.cyc & m_req_i.stb & ~m_rsp_o.ack;
         if (!lock_q)
            sel_q <= sel_now;
      end
   end

   assign sel = lock_q ? sel_q : sel_now;

   assign misc_req_o = gate_req(m_req_i, sel.misc);
   assign rb_req_o = gate_req(m_req_i, sel.rb);
   assign set_req_o = gate_req(m_req_i, sel.set);

   ////////////////////////////////////////
   // result path

   always_comb
   begin
      m_rsp_o = '0;   // unmapped, never acks
      if (sel.misc)
         m_rsp_o = misc_rsp_i;
      else if (sel.rb)
         m_rsp_o = rb_rsp_i;
      else if (sel.set)
         m_rsp_o = set_rsp_i;
   end

endmodule

/* hdl/misc_regs.sv */
`timescale 1ns/10ps

module misc_regs
  (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  wb_pkg::wb_req_t  req_i,
   output wb_pkg::wb_rsp_t  rsp_o,
   input  logic [2:0]       cgen_st_i,
   output logic [1:0]       cgen_ctrl_o,
   output logic [1:0]       debug_led_o
  );
   import wb_pkg::*;
   import regmap_pkg::*;

   logic [wb_dw-1:0] reg_leds_q;
   logic [wb_dw-1:0] reg_cgen_ctrl_q;
   logic [wb_dw-1:0] reg_test_q;
   logic             access;
   logic [6:0]       offset;

   assign access = req_i.cyc & req_i.stb;
   assign offset = req_i.adr[6:0];

   ////////////////////////////////////////
   // writes take effect on the ack cycle

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds_q <= '0;
         reg_cgen_ctrl_q <= {14'd0, cgen_ctrl_reset};
         reg_test_q <= '0;
      end
      else if (access & req_i.we)
      begin
         case (offset)
            reg_leds      : reg_leds_q <= req_i.dat;
            reg_cgen_ctrl : reg_cgen_ctrl_q <= req_i.dat;
            reg_test      : reg_test_q <= req_i.dat;
            default       : ;   // read-only or unused
         endcase
      end
   end

   ////////////////////////////////////////
   // reads

   always_comb
   begin
      rsp_o.ack = access;   // zero wait states
      case (offset)
         reg_leds      : rsp_o.dat = reg_leds_q;
         reg_cgen_ctrl : rsp_o.dat = reg_cgen_ctrl_q;
         reg_cgen_st   : rsp_o.dat = {13'd0, cgen_st_i};
         reg_test      : rsp_o.dat = reg_test_q;
         reg_compat    : rsp_o.dat = {8'd0, compat_num};
         default       : rsp_o.dat = unmapped_read;
      endcase
   end

   assign cgen_ctrl_o = reg_cgen_ctrl_q[1:0];   // {sync_b, ref_sel}
   assign debug_led_o = ~reg_leds_q[1:0];       // leds are active low

endmodule

/* hdl/settings_bus_16le.sv */
`timescale 1ns/10ps

module settings_bus_16le
  (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_pkg::wb_req_t      req_i,
   output wb_pkg::wb_rsp_t      rsp_o,
   output regmap_pkg::set_bus_t set_bus_o
  );
   import wb_pkg::*;
   import regmap_pkg::*;

   logic                 wr;
   logic [wb_dw-1:0]     data_lo_q;   // low half waits here for the high half
   logic                 stb_q;
   logic [set_rw-1:0]    addr_q;
   logic [2*wb_dw-1:0]   data_q;

   assign wr = req_i.cyc & req_i.stb & req_i.we;

   // write-only slave
   assign rsp_o.ack = req_i.cyc & req_i.stb;
   assign rsp_o.dat = '0;

   ////////////////////////////////////////
   // half-word assembly

   always_ff @(posedge wb_clk)
   begin
      if (wr & ~req_i.adr[1])
         data_lo_q <= req_i.dat;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr & req_i.adr[1])
      begin
         addr_q <= req_i.adr[set_rw+1:2];
         data_q <= {req_i.dat, data_lo_q};
      end
   end

   // high-half write fires the strobe
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         stb_q <= 1'b0;
      else
         stb_q <= wr & req_i.adr[1];
   end

   assign set_bus_o.stb = stb_q;
   assign set_bus_o.addr = addr_q;
   assign set_bus_o.data = data_q;

endmodule

/* hdl/vita_time_64.sv */
`timescale 1ns/10ps

module vita_time_64
  (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  regmap_pkg::set_bus_t set_bus_i,
   input  logic                 pps_i,
   output logic [63:0]          vita_time_o,
   output logic [63:0]          vita_time_pps_o
  );
   import regmap_pkg::*;

   logic [31:0] hi_pending_q;
   logic [63:0] time_q;
   logic [63:0] pps_time_q;
   logic [1:0]  pps_sync_q;    // async input
   logic        pps_last_q;
   logic        pps_edge;
   logic        set_hi;
   logic        set_lo;

   assign set_hi = set_bus_i.stb & (set_bus_i.addr == sr_time64);
   assign set_lo = set_bus_i.stb & (set_bus_i.addr == sr_time64 + 1'b1);

   ////////////////////////////////////////
   // counter and two-step load

   always_ff @(posedge wb_clk)
   begin
      if (set_hi)
         hi_pending_q <= set_bus_i.data;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         time_q <= '0;
      else if (set_lo)
         time_q <= {hi_pending_q, set_bus_i.data};   // low word commits
      else
         time_q <= time_q + 64'd1;
   end

   ////////////////////////////////////////
   // pps capture

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync_q <= '0;
         pps_last_q <= 1'b0;
         pps_time_q <= '0;
      end
      else
      begin
         pps_sync_q <= {pps_sync_q[0], pps_i};
         pps_last_q <= pps_sync_q[1];
         if (pps_edge)
            pps_time_q <= time_q;
      end
   end

   assign pps_edge = pps_sync_q[1] & ~pps_last_q;   // rising only

   assign vita_time_o = time_q;
   assign vita_time_pps_o = pps_time_q;

endmodule

/* hdl/readback_mux_32.sv */
`timescale 1ns/10ps

module readback_mux_32
  (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_pkg::wb_req_t      req_i,
   output wb_pkg::wb_rsp_t      rsp_o,
   input  regmap_pkg::set_bus_t set_bus_i,
   input  logic [63:0]          vita_time_i,
   input  logic [63:0]          vita_time_pps_i
  );
   import wb_pkg::*;
   import regmap_pkg::*;

   logic [31:0]      test32_q;
   logic [31:0]      word;
   logic [wb_dw-1:0] dat_q;
   logic             ack_q;

   // test register, written through the settings bus
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         test32_q <= '0;
      else if (set_bus_i.stb & (set_bus_i.addr == sr_reg_test32))
         test32_q <= set_bus_i.data;
   end

   ////////////////////////////////////////
   // word select, adr[5:2]

   always_comb
   begin
      case (req_i.adr[5:2])
         4'd0    : word = vita_time_i[63:32];
         4'd1    : word = vita_time_i[31:0];
         4'd2    : word = vita_time_pps_i[63:32];
         4'd3    : word = vita_time_pps_i[31:0];
         4'd4    : word = test32_q;
         default : word = '0;
      endcase
   end

   // one ack pulse per access, data sampled with it
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= req_i.cyc & req_i.stb & ~ack_q;
   end

   always_ff @(posedge wb_clk)
   begin
      dat_q <= req_i.adr[1] ? word[31:16] : word[15:0];   // high half on adr[1]
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;

endmodule

/* hdl/u1e_core.sv */
`timescale 1ns/10ps

module u1e_core
  (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_pkg::wb_req_t      m_req_i,
   output wb_pkg::wb_rsp_t      m_rsp_o,
   input  logic [2:0]           cgen_st_i,
   output logic [1:0]           cgen_ctrl_o,
   output logic [1:0]           debug_led_o,
   input  logic                 pps_i
  );

   wb_pkg::wb_req_t      misc_req, rb_req, set_req;
   wb_pkg::wb_rsp_t      misc_rsp, rb_rsp, set_rsp;
   regmap_pkg::set_bus_t set_bus;
   logic [63:0]          vita_time, vita_time_pps;

   ////////////////////////////////////////
   // decode

   wb_slave_decode u_decode
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_req_i(m_req_i), .m_rsp_o(m_rsp_o),
      .misc_req_o(misc_req), .rb_req_o(rb_req), .set_req_o(set_req),
      .misc_rsp_i(misc_rsp), .rb_rsp_i(rb_rsp), .set_rsp_i(set_rsp));

   ////////////////////////////////////////
   // execute

   misc_regs u_misc_regs   // slave 0
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(misc_req), .rsp_o(misc_rsp),
      .cgen_st_i(cgen_st_i), .cgen_ctrl_o(cgen_ctrl_o), .debug_led_o(debug_led_o));

   settings_bus_16le u_settings   // slaves 8 and 9
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(set_req), .rsp_o(set_rsp), .set_bus_o(set_bus));

   vita_time_64 u_vita_time
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_bus_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   ////////////////////////////////////////
   // result

   readback_mux_32 u_readback   // slave 7
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(rb_req), .rsp_o(rb_rsp), .set_bus_i(set_bus),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps));

endmodule

/* bench/tb_u1e_core.sv */
`timescale 1ns/10ps

module tb_u1e_core;
   import wb_pkg::*;

   logic        wb_clk;
   logic        wb_rst;
   wb_req_t     m_req;
   wb_rsp_t     m_rsp;
   logic [2:0]  cgen_st;
   logic [1:0]  cgen_ctrl;
   logic [1:0]  debug_led;
   logic        pps;
   integer      seed;
   int          errors;
   int          timeouts;
   int          checks;
   logic [15:0] shadow [0:2];   // leds, cgen_ctrl, test

   u1e_core u_u1e_core
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .m_req_i(m_req), .m_rsp_o(m_rsp),
      .cgen_st_i(cgen_st), .cgen_ctrl_o(cgen_ctrl), .debug_led_o(debug_led), .pps_i(pps));

   initial
   begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;
   end

   // slave number in adr[10:7]
   function automatic logic [10:0] misc_adr(input logic [6:0] off);
      return {4'd0, off};
   endfunction

   function automatic logic [10:0] set_adr(input logic [5:0] num, input logic hi);
      return {3'b100, num, hi, 1'b0};   // setting number overlaps slave bit 7
   endfunction

   function automatic logic [10:0] rb_adr(input logic [3:0] word, input logic hi);
      return {4'd7, 1'b0, word, hi, 1'b0};
   endfunction

   ////////////////////////////////////////
   // bus master

   // ack is sampled on the falling edge, after the slaves have settled
   task automatic wait_ack(input int limit, output logic acked);
      int n;
      acked = 1'b0;
      n = 0;
      while (!acked && n < limit)
      begin
         @(posedge wb_clk);
         @(negedge wb_clk);
         acked = m_rsp.ack;
         n++;
      end
   endtask

   task automatic wb_write(input logic [10:0] adr, input logic [15:0] dat);
      logic acked;
      @(negedge wb_clk);   // stb stays low for at least one edge between accesses
      m_req.adr = adr;
      m_req.dat = dat;
      m_req.sel = 2'b11;
      m_req.we = 1'b1;
      m_req.cyc = 1'b1;
      m_req.stb = 1'b1;
      wait_ack(20, acked);
      m_req.cyc = 1'b0;
      m_req.stb = 1'b0;
      m_req.we = 1'b0;
      if (!acked)
      begin
         timeouts++;
         $display("no ack for write to address %h within 20 cycles at %0t ns", adr, $time);
      end
   endtask

   task automatic wb_read(input logic [10:0] adr, output logic [15:0] dat,
                          output logic acked);
      @(negedge wb_clk);
      m_req.adr = adr;
      m_req.sel = 2'b11;
      m_req.we = 1'b0;
      m_req.cyc = 1'b1;
      m_req.stb = 1'b1;
      wait_ack(20, acked);
      dat = m_rsp.dat;   // taken before the request drops
      m_req.cyc = 1'b0;
      m_req.stb = 1'b0;
   endtask

   task automatic read_word(input logic [10:0] adr, output logic [15:0] dat);
      logic acked;
      wb_read(adr, dat, acked);
      if (!acked)
      begin
         timeouts++;
         $display("no ack for read from address %h within 20 cycles at %0t ns", adr, $time);
      end
   endtask

   task automatic read32(input logic [3:0] word, output logic [31:0] v);
      logic [15:0] lo;
      logic [15:0] hi;
      read_word(rb_adr(word, 1'b0), lo);
      read_word(rb_adr(word, 1'b1), hi);
      v = {hi, lo};
   endtask

   task automatic set_write(input logic [5:0] num, input logic [31:0] v);
      wb_write(set_adr(num, 1'b0), v[15:0]);
      wb_write(set_adr(num, 1'b1), v[31:16]);   // strobe follows this one
   endtask

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   ////////////////////////////////////////
   // stimulus

   initial
   begin
      logic [15:0] got;
      logic [31:0] val;
      logic [31:0] h;
      logic [31:0] l;
      logic [31:0] t1;
      logic [31:0] t2;
      logic [31:0] p;
      logic        acked;
      int          pick;
      seed = 77149;
      errors = 0;
      timeouts = 0;
      checks = 0;
      m_req = '0;
      pps = 1'b0;
      cgen_st = $random(seed);
      wb_rst = 1'b1;
      shadow[0] = 16'h0000;
      shadow[1] = 16'h0003;
      shadow[2] = 16'h0000;
      repeat (5) @(negedge wb_clk);
      wb_rst = 1'b0;

      // reset values of slave 0
      read_word(misc_adr(7'd4), got);
      compare("cgen_ctrl after reset", got, 32'd3);
      compare("cgen_ctrl_o after reset", {30'd0, cgen_ctrl}, 32'd3);
      read_word(misc_adr(7'd16), got);
      compare("compat number", got, 32'd3);
      read_word(misc_adr(7'd6), got);
      compare("cgen status", got, {29'd0, cgen_st});
      read_word(misc_adr(7'd2), got);
      compare("unused offset", got, 32'h0000BEEF);

      for (int i = 0; i < 24; i++)
      begin
         pick = {$random(seed)} % 3;
         val = $random(seed);
         if (val[31])
         begin
            wb_write(misc_adr({pick[4:0], 2'b00}), val[15:0]);
            shadow[pick] = val[15:0];
         end
         else
         begin
            read_word(misc_adr({pick[4:0], 2'b00}), got);
            compare("misc register", got, {16'd0, shadow[pick]});
         end
         compare("debug_led_o", {30'd0, debug_led}, {30'd0, ~shadow[0][1:0]});
         compare("cgen_ctrl_o", {30'd0, cgen_ctrl}, {30'd0, shadow[1][1:0]});
      end

      // test32 through the settings bus
      for (int i = 0; i < 4; i++)
      begin
         val = $random(seed);
         set_write(6'd52, val);
         read32(4'd4, t1);
         compare("test32 readback", t1, val);
      end

      ////////////////////////////////////////
      // time load and pps capture

      h = $random(seed);
      l = $random(seed);
      l[31] = 1'b0;
      l[15:12] = 4'h0;   // low half cannot wrap between two half reads
      set_write(6'd40, h);
      set_write(6'd41, l);
      read32(4'd0, t1);
      compare("time high after load", t1, h);
      read32(4'd1, t1);
      read32(4'd1, t2);
      compare("time low advances", {31'd0, t2 > t1}, 32'd1);

      @(negedge wb_clk);
      pps = 1'b1;
      repeat (10) @(negedge wb_clk);
      pps = 1'b0;
      read32(4'd2, t1);
      compare("pps time high", t1, h);
      read32(4'd3, p);
      read32(4'd1, t2);
      compare("pps time low not ahead", {31'd0, p <= t2}, 32'd1);

      // slave 3 is unmapped, the timeout is the expected result
      wb_read({4'd3, 7'd0}, got, acked);
      checks++;
      assert (!acked)
      else
      begin
         errors++;
         $display("read from unmapped slave 3 was acknowledged at %0t ns", $time);
      end
      read_word(misc_adr(7'd16), got);
      compare("compat after unmapped access", got, 32'd3);

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* sim.f */
hdl/wb_pkg.sv
hdl/regmap_pkg.sv
hdl/wb_slave_decode.sv
hdl/misc_regs.sv
hdl/settings_bus_16le.sv
hdl/vita_time_64.sv
hdl/readback_mux_32.sv
hdl/u1e_core.sv
bench/tb_u1e_core.sv
